// ==== Bender.yml ====
package:
  name: csr_config

sources:
  - hw/mem_resp_pkg.sv
  - hw/csr_cfg_pkg.sv
  - hw/fifo_rd_if.sv
  - hw/sync_fifo.sv
  - hw/response_filter.sv
  - hw/config_assembler.sv
  - hw/csr_config_top.sv
  - target: test
    files:
      - bench/csr_config_assert.sv
      - bench/tb_csr_config.sv

// ==== bench/csr_config_assert.sv ====
/* Concurrent checks bound into csr_config_top
   error_count holds the number of failed checks */
`timescale 1ns/10ps
`default_nettype none

module csr_config_assert (
    input wire logic ap_clk,
    input wire logic areset_csr_index_generator,
    input wire logic config_rd_en,
    input wire logic config_valid,
    input wire logic cfg_wr_en
);

    int error_count = 0;

    // Output quiet while reset is applied
    valid_low_in_reset: assert property (
        @(posedge ap_clk) areset_csr_index_generator |=> !config_valid
    ) else begin
        $error("config_valid high during reset");
        error_count++;
    end

    // Registered read level plus FIFO latency
    valid_after_read: assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        config_valid |-> $past(config_rd_en, 2)
    ) else begin
        $error("config_valid without config_rd_en two cycles earlier");
        error_count++;
    end

    // One record strobe per completed mask
    single_record_pulse: assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        cfg_wr_en |=> !cfg_wr_en
    ) else begin
        $error("record write strobe high on two consecutive cycles");
        error_count++;
    end

endmodule

bind csr_config_top csr_config_assert assert_i (
    .ap_clk                    (ap_clk),
    .areset_csr_index_generator(areset_csr_index_generator),
    .config_rd_en              (config_rd_en),
    .config_valid              (config_valid),
    .cfg_wr_en                 (cfg_wr_en)
);

`default_nettype wire

// ==== bench/tb_csr_config.sv ====
/* Testbench for the collector in engine slot 2 with table rows and random stray responses
   Responses are paced so the input FIFO never overflows; 200 cycles allowed per row */
`timescale 1ns/10ps
`default_nettype none

module tb_csr_config;

    localparam int SLOT       = 2;
    localparam int WORDS      = 6;
    localparam int WIN_BASE   = SLOT * WORDS;
    localparam int NUM_FIXED  = 6;
    localparam int NUM_ROWS   = 16;
    localparam int CLK_PERIOD = 40;

    // Class, base shift, first index, reverse order, duplicate, read held low, six words
    typedef struct packed {
        mem_resp_pkg::buffer_class_e cls;
        logic [3:0]                  shift;
        logic [2:0]                  first;
        logic                        rev;
        logic                        dup;
        logic                        hold;
        logic [WORDS*32-1:0]         words;
    } row_t;

    logic                                     ap_clk;
    logic                                     areset_csr_index_generator;
    logic                                     resp_valid;
    mem_resp_pkg::buffer_class_e              resp_buffer;
    logic [mem_resp_pkg::RESP_OFFSET_W-1:0]   resp_offset;
    logic [mem_resp_pkg::RESP_SHIFT_W-1:0]    resp_shift;
    logic [mem_resp_pkg::RESP_DATA_W-1:0]     resp_data;
    logic                                     response_rd_en;
    logic                                     config_rd_en;
    logic                                     config_valid;
    csr_cfg_pkg::csr_index_config_t           config_out;

    integer                         seed = 20375;
    row_t                           rows [NUM_ROWS];
    csr_cfg_pkg::csr_index_config_t expected_q [$];

    csr_config_top #(
        .ENGINE_SLOT(SLOT),
        .FIFO_DEPTH (16),
        .PROG_THRESH(8)
    ) dut_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_buffer               (resp_buffer),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .response_rd_en            (response_rd_en),
        .config_rd_en              (config_rd_en),
        .config_valid              (config_valid),
        .config_out                (config_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Expected record from the word layout
    function automatic csr_cfg_pkg::csr_index_config_t decode_words(
        input logic [WORDS*32-1:0] words);
        csr_cfg_pkg::csr_index_config_t rec;
        rec.increment       = words[0];
        rec.decrement       = words[1];
        rec.mode_sequence   = words[2];
        rec.mode_buffer     = words[3];
        rec.index_start     = words[32 +: 32];
        rec.index_end       = words[64 +: 32];
        rec.stride          = words[96 +: 32];
        rec.granularity     = words[128 +: 31];
        rec.shift_direction = words[159];
        rec.cmd             = csr_cfg_pkg::memory_cmd_e'(words[160 +: 3]);
        return rec;
    endfunction

    function automatic row_t make_row(input mem_resp_pkg::buffer_class_e cls, input int shift,
        input int first, input bit rev, input bit dup, input bit hold,
        input logic [WORDS*32-1:0] words);
        row_t row;
        row.cls   = cls;
        row.shift = 4'(shift);
        row.first = 3'(first);
        row.rev   = rev;
        row.dup   = dup;
        row.hold  = hold;
        row.words = words;
        return row;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic load_table();
        // Words listed as {w5, w4, w3, w2, w1, w0}
        rows[0] = make_row(mem_resp_pkg::STRUCT_CU_SETUP, 0, 0, 0, 0, 0,
            {32'h0000_0001, 32'h0000_0008, 32'h0000_0004, 32'h0000_0100,
             32'h0000_0010, 32'h0000_0005});
        rows[1] = make_row(mem_resp_pkg::STRUCT_ENGINE_SETUP, 3, 2, 1, 1, 0,
            {32'hDEAD_BEE2, 32'h8000_0003, 32'hFFFF_FFFF, 32'h89AB_CDEF,
             32'h1234_5678, 32'hFFFF_FFFA});
        rows[2] = make_row(mem_resp_pkg::STRUCT_CU_SETUP, 7, 5, 0, 0, 0,
            {32'h0000_0003, 32'h7FFF_FFFF, 32'h0000_0010, 32'h7FFF_FFFF,
             32'h0000_0000, 32'h0000_000C});
        rows[3] = make_row(mem_resp_pkg::STRUCT_ENGINE_SETUP, 11, 3, 1, 1, 0,
            {32'h0000_0004, 32'hFFFF_FFFF, 32'h0000_0100, 32'hCAFE_FFFF,
             32'hCAFE_0000, 32'h0000_0003});
        rows[4] = make_row(mem_resp_pkg::STRUCT_CU_SETUP, 5, 1, 0, 1, 0,
            {32'hFFFF_FFF8, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000,
             32'h0000_0040, 32'h0000_0009});
        rows[5] = make_row(mem_resp_pkg::STRUCT_ENGINE_SETUP, 2, 4, 1, 0, 0,
            {32'h0000_0002, 32'h4000_1000, 32'h0000_0020, 32'h0001_0000,
             32'h0000_0200, 32'h0000_0006});
        // Random words, filled in when applied
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            rows[r] = make_row(mem_resp_pkg::STRUCT_ENGINE_SETUP, 0, 0, 0, 0, 1, '0);
        end
    endtask

    task automatic drive_resp(input mem_resp_pkg::buffer_class_e cls, input int seq,
        input int shift, input logic [31:0] data);
        @(posedge ap_clk);
        resp_valid  <= 1'b1;
        resp_buffer <= cls;
        resp_offset <= 16'(seq << shift);
        resp_shift  <= 5'(shift);
        resp_data   <= data;
        @(posedge ap_clk);
        resp_valid <= 1'b0;
        repeat (2) @(posedge ap_clk);
    endtask

    task automatic send_stray();
        mem_resp_pkg::buffer_class_e cls;
        int                          seq;
        int                          pick;
        pick = rand_below(3);
        if (rand_below(2) == 0) begin
            // Foreign class inside the window
            cls = (pick == 0) ? mem_resp_pkg::STRUCT_INVALID :
                  (pick == 1) ? mem_resp_pkg::STRUCT_IN_DATA : mem_resp_pkg::STRUCT_OUT_DATA;
            seq = WIN_BASE + rand_below(WORDS);
        end else begin
            // Setup class outside the window
            cls = (pick == 0) ? mem_resp_pkg::STRUCT_ENGINE_SETUP : mem_resp_pkg::STRUCT_CU_SETUP;
            seq = (pick == 2) ? WIN_BASE + WORDS + rand_below(20) : rand_below(WIN_BASE);
        end
        drive_resp(cls, seq, rand_below(11), $random(seed));
    endtask

    task automatic apply_row(input row_t row);
        logic [WORDS*32-1:0]         words;
        mem_resp_pkg::buffer_class_e cls;
        int                          base_shift;
        int                          first;
        int                          idx;
        bit                          rev;
        words      = row.words;
        cls        = row.cls;
        base_shift = row.shift;
        first      = row.first;
        rev        = row.rev;
        if (row.hold) begin
            // Drain earlier records before the read side is held
            while (config_rd_en && expected_q.size() != 0) @(posedge ap_clk);
            for (int k = 0; k < WORDS; k++) begin
                words[k*32 +: 32] = $random(seed);
            end
            words[5*32 +: 3] = 3'(rand_below(5));
            base_shift = rand_below(12);
            first      = rand_below(WORDS);
            rev        = rand_below(2);
        end
        expected_q.push_back(decode_words(words));
        @(posedge ap_clk);
        config_rd_en <= ~row.hold;
        // Stale copy first, so the later word must win
        if (row.dup) begin
            drive_resp(cls, WIN_BASE + first, base_shift, words[first*32 +: 32] ^ 32'hA5A5_5A5A);
        end
        for (int k = 0; k < WORDS; k++) begin
            idx = rev ? (first + WORDS - k) % WORDS : (first + k) % WORDS;
            if (row.hold) begin
                cls = rand_below(2) ? mem_resp_pkg::STRUCT_CU_SETUP
                                    : mem_resp_pkg::STRUCT_ENGINE_SETUP;
            end
            drive_resp(cls, WIN_BASE + idx, (base_shift + k) % 12, words[idx*32 +: 32]);
            if (rand_below(4) == 0) begin
                send_stray();
            end
        end
    endtask

    // Pop side of the input FIFO toggles at random
    always @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            response_rd_en <= 1'b0;
        end else begin
            response_rd_en <= (rand_below(2) == 0);
        end
    end

    // --------------------
    // Output check
    // --------------------
    task automatic check_record();
        csr_cfg_pkg::csr_index_config_t exp;
        assert (expected_q.size() != 0) else
            report_failure($sformatf("Record appeared at %0t with none pending", $time));
        exp = expected_q.pop_front();
        assert (config_out === exp) else
            report_failure($sformatf("MISMATCH time=%0t config_out expected=%h actual=%h",
                $time, exp, config_out));
    endtask

    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && config_valid === 1'b1) begin
            check_record();
        end
    end

    // Bound checker failures end the run at once
    always @(dut_i.assert_i.error_count) begin
        if (dut_i.assert_i.error_count != 0) begin
            report_failure($sformatf("Bound assertion failed at %0t", $time));
        end
    end

    initial begin
        repeat (NUM_ROWS * 200) @(posedge ap_clk);
        $display("Timeout, %0d records still outstanding", expected_q.size());
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        areset_csr_index_generator = 1'b1;
        resp_valid     = 1'b0;
        resp_buffer    = mem_resp_pkg::STRUCT_INVALID;
        resp_offset    = '0;
        resp_shift     = '0;
        resp_data      = '0;
        response_rd_en = 1'b0;
        config_rd_en   = 1'b0;
        load_table();
        repeat (10) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;
        // Quiet output before any stimulus
        repeat (8) begin
            @(negedge ap_clk);
            assert (config_valid === 1'b0) else
                report_failure($sformatf("MISMATCH time=%0t config_valid expected=0 actual=%b",
                    $time, config_valid));
        end
        @(posedge ap_clk);
        config_rd_en <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(rows[r]);
        end
        @(posedge ap_clk);
        config_rd_en <= 1'b1;
        while (expected_q.size() != 0) @(posedge ap_clk);
        // Room for any extra record to show up
        repeat (20) @(posedge ap_clk);
        if (dut_i.assert_i.error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("Bound assertions failed %0d times", dut_i.assert_i.error_count);
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/config_assembler.sv ====
/* Collects the six words of one engine into a record, a repeated index overwrites
   Pops stop while the output FIFO is at its programmable-full level */
`timescale 1ns/10ps
`default_nettype none

module config_assembler (
    input  wire logic                  ap_clk,
    input  wire logic                  areset_csr_index_generator,
    input  wire logic                  response_rd_en,
    fifo_rd_if.reader                  in_rd,
    fifo_rd_if.monitor                 out_mon,
    output logic                       cfg_wr_en,
    output csr_cfg_pkg::csr_index_config_t cfg_data
);

    localparam int WORDS  = csr_cfg_pkg::CFG_WORD_COUNT;
    localparam int DATA_W = mem_resp_pkg::RESP_DATA_W;

    csr_cfg_pkg::cfg_word_t         word_in;
    csr_cfg_pkg::csr_index_config_t fields;
    logic [WORDS-1:0]               seen_mask;
    logic [WORDS-1:0]               word_bit;
    logic                           record_full;

    assign word_in     = csr_cfg_pkg::cfg_word_t'(in_rd.dout);
    assign record_full = &seen_mask;

    // --------------------
    // Pop control
    // --------------------
    assign in_rd.rd_en = ~in_rd.empty & response_rd_en & ~record_full & ~out_mon.prog_full;

    // One-hot of the word arriving this cycle
    always_comb begin
        word_bit = '0;
        if (in_rd.valid && (word_in.index < csr_cfg_pkg::CFG_INDEX_W'(WORDS))) begin
            word_bit[word_in.index] = 1'b1;
        end
    end

    // --------------------
    // Seen mask and record strobe
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            seen_mask <= '0;
            cfg_wr_en <= 1'b0;
        end else begin
            cfg_wr_en <= record_full;
            // A word landing in the completion cycle opens the next record
            seen_mask <= (record_full ? '0 : seen_mask) | word_bit;
        end
    end

    // --------------------
    // Field update
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (in_rd.valid) begin
            case (word_in.index)
                csr_cfg_pkg::WORD_MODE: begin
                    fields.increment     <= word_in.data[0];
                    fields.decrement     <= word_in.data[1];
                    fields.mode_sequence <= word_in.data[2];
                    fields.mode_buffer   <= word_in.data[3];
                end
                csr_cfg_pkg::WORD_INDEX_START: begin
                    fields.index_start <= word_in.data;
                end
                csr_cfg_pkg::WORD_INDEX_END: begin
                    fields.index_end <= word_in.data;
                end
                csr_cfg_pkg::WORD_STRIDE: begin
                    fields.stride <= word_in.data;
                end
                csr_cfg_pkg::WORD_GRANULARITY: begin
                    fields.granularity     <= word_in.data[csr_cfg_pkg::GRAN_W-1:0];
                    // Top bit selects the shift direction
                    fields.shift_direction <= word_in.data[DATA_W-1];
                end
                csr_cfg_pkg::WORD_CMD: begin
                    fields.cmd <= csr_cfg_pkg::memory_cmd_e'(
                        word_in.data[csr_cfg_pkg::CMD_W-1:0]);
                end
                default: ;
            endcase
        end
    end

    // Snapshot taken before any word of the next record lands
    always_ff @(posedge ap_clk) begin
        if (record_full) begin
            cfg_data <= fields;
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_cfg_pkg.sv ====
/* Layout of the six configuration words of one stride index engine
   Word 5 decodes only its low command bits, the rest of that word is ignored */
`default_nettype none

package csr_cfg_pkg;

    // --------------------
    // Word layout
    // --------------------

    // Words per engine window and the relative index that addresses them
    parameter int CFG_WORD_COUNT = 6;
    parameter int CFG_INDEX_W    = 3;

    // Field widths inside the words
    parameter int CMD_W  = 3;
    parameter int GRAN_W = 31;

    // Relative word indices
    parameter logic [CFG_INDEX_W-1:0] WORD_MODE        = 3'd0;
    parameter logic [CFG_INDEX_W-1:0] WORD_INDEX_START = 3'd1;
    parameter logic [CFG_INDEX_W-1:0] WORD_INDEX_END   = 3'd2;
    parameter logic [CFG_INDEX_W-1:0] WORD_STRIDE      = 3'd3;
    parameter logic [CFG_INDEX_W-1:0] WORD_GRANULARITY = 3'd4;
    parameter logic [CFG_INDEX_W-1:0] WORD_CMD         = 3'd5;

    // --------------------
    // Types
    // --------------------

    typedef enum logic [CMD_W-1:0] {
        CMD_INVALID      = 3'd0,
        CMD_MEM_READ     = 3'd1,
        CMD_MEM_WRITE    = 3'd2,
        CMD_STREAM_READ  = 3'd3,
        CMD_STREAM_WRITE = 3'd4
    } memory_cmd_e;

    // Entry of the input queue
    typedef struct packed {
        logic [CFG_INDEX_W-1:0]               index;
        logic [mem_resp_pkg::RESP_DATA_W-1:0] data;
    } cfg_word_t;

    typedef struct packed {
        logic                                 increment;
        logic                                 decrement;
        logic                                 mode_sequence;
        logic                                 mode_buffer;
        logic [mem_resp_pkg::RESP_DATA_W-1:0] index_start;
        logic [mem_resp_pkg::RESP_DATA_W-1:0] index_end;
        logic [mem_resp_pkg::RESP_DATA_W-1:0] stride;
        logic [GRAN_W-1:0]                    granularity;
        logic                                 shift_direction;
        memory_cmd_e                          cmd;
    } csr_index_config_t;

endpackage

`default_nettype wire

// ==== hw/csr_config_top.sv ====
/* Configuration collector for one stride index engine in slot ENGINE_SLOT
   Accepted responses are dropped when the input FIFO is full */
`timescale 1ns/10ps
`default_nettype none

module csr_config_top #(
    parameter int ENGINE_SLOT = 0,
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  wire logic                                   ap_clk,
    input  wire logic                                   areset_csr_index_generator,
    input  wire logic                                   resp_valid,
    input  wire mem_resp_pkg::buffer_class_e            resp_buffer,
    input  wire logic [mem_resp_pkg::RESP_OFFSET_W-1:0] resp_offset,
    input  wire logic [mem_resp_pkg::RESP_SHIFT_W-1:0]  resp_shift,
    input  wire logic [mem_resp_pkg::RESP_DATA_W-1:0]   resp_data,
    input  wire logic                                   response_rd_en,
    input  wire logic                                   config_rd_en,
    output logic                                        config_valid,
    output csr_cfg_pkg::csr_index_config_t              config_out
);

    localparam int WORD_W = $bits(csr_cfg_pkg::cfg_word_t);
    localparam int CFG_W  = $bits(csr_cfg_pkg::csr_index_config_t);

    logic                           resp_wr_en;
    csr_cfg_pkg::cfg_word_t         resp_word;
    logic                           cfg_wr_en;
    csr_cfg_pkg::csr_index_config_t cfg_data;

    fifo_rd_if #(.WIDTH(WORD_W)) in_rd ();
    fifo_rd_if #(.WIDTH(CFG_W))  cfg_rd ();

    // --------------------
    // Input path
    // --------------------
    response_filter #(
        .ENGINE_SLOT(ENGINE_SLOT)
    ) filter_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_buffer               (resp_buffer),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .wr_en                     (resp_wr_en),
        .word                      (resp_word)
    );

    sync_fifo #(
        .WIDTH      (WORD_W),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) resp_fifo_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (resp_wr_en),
        .din                       (resp_word),
        .rd                        (in_rd)
    );

    config_assembler assembler_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_rd_en            (response_rd_en),
        .in_rd                     (in_rd),
        .out_mon                   (cfg_rd),
        .cfg_wr_en                 (cfg_wr_en),
        .cfg_data                  (cfg_data)
    );

    // --------------------
    // Output path
    // --------------------
    sync_fifo #(
        .WIDTH      (CFG_W),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) cfg_fifo_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (cfg_wr_en),
        .din                       (cfg_data),
        .rd                        (cfg_rd)
    );

    // Registered read level, so valid trails config_rd_en by two cycles
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            cfg_rd.rd_en <= 1'b0;
        end else begin
            cfg_rd.rd_en <= config_rd_en;
        end
    end

    assign config_valid = cfg_rd.valid;
    assign config_out   = csr_cfg_pkg::csr_index_config_t'(cfg_rd.dout);

endmodule

`default_nettype wire

// ==== hw/fifo_rd_if.sv ====
/* Read side of a synchronous FIFO, dout is valid only in the cycle valid is high */
`timescale 1ns/10ps
`default_nettype none

interface fifo_rd_if #(
    parameter int WIDTH = 32
);

    logic             rd_en;
    logic             valid;
    logic [WIDTH-1:0] dout;
    logic             empty;
    logic             prog_full;

    // FIFO side
    modport fifo (input rd_en, output valid, output dout, output empty, output prog_full);

    // Consumer that pops
    modport reader (output rd_en, input valid, input dout, input empty, input prog_full);

    // Observer only
    modport monitor (input rd_en, input valid, input dout, input empty, input prog_full);

endinterface

`default_nettype wire

// ==== hw/mem_resp_pkg.sv ====
/* Memory response fields as seen by one configuration collector
   Offset and sequence number share one width; shifts above 15 clear the sequence */
`default_nettype none

package mem_resp_pkg;

    // --------------------
    // Field widths
    // --------------------

    // One response data word
    parameter int RESP_DATA_W = 32;

    // Word offset, also the width of the derived sequence number
    parameter int RESP_OFFSET_W = 16;

    // Right-shift amount applied to the offset
    parameter int RESP_SHIFT_W = 5;

    // Buffer class encoding
    parameter int BUFFER_CLASS_W = 3;

    // --------------------
    // Buffer classes
    // --------------------

    // Only the two setup classes carry configuration words
    typedef enum logic [BUFFER_CLASS_W-1:0] {
        STRUCT_INVALID      = 3'd0,
        STRUCT_CU_SETUP     = 3'd1,
        STRUCT_ENGINE_SETUP = 3'd2,
        STRUCT_IN_DATA      = 3'd3,
        STRUCT_OUT_DATA     = 3'd4
    } buffer_class_e;

endpackage

`default_nettype wire

// ==== hw/response_filter.sv ====
/* Registers a memory response and keeps setup words inside this engine's window
   The window base ENGINE_SLOT*CFG_WORD_COUNT must fit the offset width */
`timescale 1ns/10ps
`default_nettype none

module response_filter #(
    parameter int ENGINE_SLOT = 0
) (
    input  wire logic                                      ap_clk,
    input  wire logic                                      areset_csr_index_generator,
    input  wire logic                                      resp_valid,
    input  wire mem_resp_pkg::buffer_class_e               resp_buffer,
    input  wire logic [mem_resp_pkg::RESP_OFFSET_W-1:0]    resp_offset,
    input  wire logic [mem_resp_pkg::RESP_SHIFT_W-1:0]     resp_shift,
    input  wire logic [mem_resp_pkg::RESP_DATA_W-1:0]      resp_data,
    output logic                                           wr_en,
    output csr_cfg_pkg::cfg_word_t                         word
);

    localparam int OFFSET_W = mem_resp_pkg::RESP_OFFSET_W;

    // Window of sequence numbers owned by this engine
    localparam logic [OFFSET_W-1:0] WIN_BASE =
        OFFSET_W'(ENGINE_SLOT * csr_cfg_pkg::CFG_WORD_COUNT);
    localparam logic [OFFSET_W-1:0] WIN_END =
        OFFSET_W'((ENGINE_SLOT + 1) * csr_cfg_pkg::CFG_WORD_COUNT);

    logic                                   valid_q;
    mem_resp_pkg::buffer_class_e            buffer_q;
    logic [OFFSET_W-1:0]                    offset_q;
    logic [mem_resp_pkg::RESP_SHIFT_W-1:0]  shift_q;
    logic [mem_resp_pkg::RESP_DATA_W-1:0]   data_q;
    logic [OFFSET_W-1:0]                    seq_num;
    logic [OFFSET_W-1:0]                    rel_seq;
    logic                                   class_ok;
    logic                                   in_window;

    // --------------------
    // Input register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        buffer_q <= resp_buffer;
        offset_q <= resp_offset;
        shift_q  <= resp_shift;
        data_q   <= resp_data;
    end

    // --------------------
    // Class and window check
    // --------------------
    assign seq_num   = offset_q >> shift_q;
    assign rel_seq   = seq_num - WIN_BASE;
    assign class_ok  = (buffer_q == mem_resp_pkg::STRUCT_CU_SETUP) ||
                       (buffer_q == mem_resp_pkg::STRUCT_ENGINE_SETUP);
    assign in_window = (seq_num >= WIN_BASE) && (seq_num < WIN_END);

    // Push in the same cycle as the register output
    assign wr_en      = valid_q & class_ok & in_window;
    assign word.index = rel_seq[csr_cfg_pkg::CFG_INDEX_W-1:0];
    assign word.data  = data_q;

endmodule

`default_nettype wire

// ==== hw/sync_fifo.sv ====
/* Synchronous FIFO, one cycle read latency; writes while full are dropped
   DEPTH must be at least 2, read requests while empty are ignored */
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  wire logic             ap_clk,
    input  wire logic             areset_csr_index_generator,
    input  wire logic             wr_en,
    input  wire logic [WIDTH-1:0] din,
    fifo_rd_if.fifo               rd
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);
    localparam logic [CNT_W-1:0] PROG_CNT  = CNT_W'(PROG_THRESH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    assign rd.empty     = (count == '0);
    assign rd.prog_full = (count >= PROG_CNT);

    assign wr_ok = wr_en & (count != FULL_CNT);
    assign rd_ok = rd.rd_en & ~rd.empty;

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd.valid <= 1'b0;
        end else begin
            rd.valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // --------------------
    // Storage and read data
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            rd.dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/mem_resp_pkg.sv
hw/csr_cfg_pkg.sv
hw/fifo_rd_if.sv
hw/sync_fifo.sv
hw/response_filter.sv
hw/config_assembler.sv
hw/csr_config_top.sv
bench/csr_config_assert.sv
bench/tb_csr_config.sv
